//--- logic/cdc_clear_defs.svh
/*
  Build-time constants for the two-sided clear sequencer.
  Included by the phase package and both halves of the phase crossing,
  override before inclusion only if every user sees the same value.
*/
`ifndef CDC_CLEAR_DEFS_SVH
`define CDC_CLEAR_DEFS_SVH

// flops in each request and acknowledge synchronizer chain
`define CDC_CLEAR_SYNC_STAGES 2

// width of one phase message on the crossing
`define CDC_CLEAR_PHASE_W 2

`endif

//--- logic/clear_phase_pkg.sv
/*
  Phase encoding of the clear sequence.
  This is the only payload that crosses between the two clock domains,
  both the initiator and the receiver interpret it the same way.
*/
`include "cdc_clear_defs.svh"

package clear_phase_pkg;

  // order follows the sequence, isolate stays up in every phase but idle
  typedef enum logic [`CDC_CLEAR_PHASE_W-1:0] {
    PHASE_IDLE,
    PHASE_ISOLATE,
    PHASE_CLEAR,
    PHASE_POST_CLEAR
  } clear_phase_e;

endpackage

//--- logic/clear_fsm_pkg.sv
/*
  State encoding of the local clear initiator FSM.
  Shared with the side wrapper so that its checks can observe the FSM.
*/
package clear_fsm_pkg;

  // the wait states cover both orders of phase delivery and local acknowledge
  typedef enum logic [3:0] {
    IDLE,
    ISOLATE,
    WAIT_ISOLATE_PHASE_ACK,
    WAIT_ISOLATE_ACK,
    CLEAR,
    WAIT_CLEAR_PHASE_ACK,
    WAIT_CLEAR_ACK,
    POST_CLEAR,
    FINISHED
  } initiator_state_e;

endpackage

//--- logic/clear_side_if.sv
/*
  Side-facing isolate and clear handshake of one clock domain.
  The sequencer drives isolate and clear through the ctrl modport,
  the surrounding logic answers with the two acknowledge levels.
*/
`timescale 1ns/1ps

interface clear_side_if;

  // isolate must be acknowledged before clear may rise
  logic isolate;
  logic isolate_ack;
  logic clear;
  logic clear_ack;

  modport ctrl (
    output isolate,
    output clear,
    input  isolate_ack,
    input  clear_ack
  );

  modport mon (input isolate, input isolate_ack, input clear, input clear_ack);

endinterface

//--- logic/phase_cdc_src.sv
/*
  Sending half of the four-phase phase-message crossing.
  A phase offered with valid_i is latched and announced with a request,
  ready_o pulses only once the far side has acknowledged it, so the
  local FSM never runs ahead of the other domain.
*/
`timescale 1ns/1ps
`include "cdc_clear_defs.svh"

module phase_cdc_src (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  clear_phase_pkg::clear_phase_e phase_i,
  input  logic                          valid_i,
  output logic                          ready_o,
  output logic                          async_req_o,
  output clear_phase_pkg::clear_phase_e async_phase_o,
  input  logic                          async_ack_i
);
  import clear_phase_pkg::*;

  logic [`CDC_CLEAR_SYNC_STAGES-1:0] ack_sync_q;
  logic                              ack_sync;
  logic                              req_q;
  clear_phase_e                      phase_q;

  // ------------------------------
  // acknowledge synchronizer
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_sync_q <= '0;
    end else begin
      ack_sync_q <= {ack_sync_q[`CDC_CLEAR_SYNC_STAGES-2:0], async_ack_i};
    end
  end

  assign ack_sync = ack_sync_q[`CDC_CLEAR_SYNC_STAGES-1];

  // ------------------------------
  // four-phase cycle
  // ------------------------------
  // a new phase is only accepted with request and synchronized ack both low,
  // so the previous cycle has fully returned to zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else if (!req_q && !ack_sync && valid_i) begin
      req_q <= 1'b1;
    end else if (req_q && ack_sync) begin
      req_q <= 1'b0;
    end
  end

  // the phase is bundled data and only has to be stable while req is high
  always_ff @(posedge clk_i) begin
    if (!req_q && !ack_sync && valid_i) begin
      phase_q <= phase_i;
    end
  end

  // the far side has taken the phase in the cycle ack shows up here
  assign ready_o       = req_q && ack_sync;
  assign async_req_o   = req_q;
  assign async_phase_o = phase_q;

  // the destination samples the phase at an unknown time while req is high
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    async_req_o && $past(async_req_o) |-> $stable(async_phase_o))
    else $error("phase changed while the crossing request was high");

endmodule

//--- logic/phase_cdc_dst.sv
/*
  Receiving half of the four-phase phase-message crossing.
  The request is synchronized, the phase is captured and offered with
  valid_o until the consumer takes it, then acknowledged back to the
  source. The acknowledge returns low once the request has fallen.
*/
`timescale 1ns/1ps
`include "cdc_clear_defs.svh"

module phase_cdc_dst (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          async_req_i,
  input  clear_phase_pkg::clear_phase_e async_phase_i,
  output logic                          async_ack_o,
  output clear_phase_pkg::clear_phase_e phase_o,
  output logic                          valid_o,
  input  logic                          take_i
);
  import clear_phase_pkg::*;

  logic [`CDC_CLEAR_SYNC_STAGES-1:0] req_sync_q;
  logic                              req_sync;
  logic                              valid_q;
  logic                              ack_q;
  clear_phase_e                      phase_q;

  // request synchronizer, the phase itself is held stable by the source
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_sync_q <= '0;
    end else begin
      req_sync_q <= {req_sync_q[`CDC_CLEAR_SYNC_STAGES-2:0], async_req_i};
    end
  end

  assign req_sync = req_sync_q[`CDC_CLEAR_SYNC_STAGES-1];

  // ------------------------------
  // offer, take and acknowledge
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      // a fresh request is offered once, never again until ack returns low
      if (req_sync && !ack_q && !valid_q) begin
        valid_q <= 1'b1;
      end else if (valid_q && take_i) begin
        valid_q <= 1'b0;
        ack_q   <= 1'b1;
      end
      if (!req_sync && ack_q) begin
        ack_q <= 1'b0;
      end
    end
  end

  // capture the phase together with the rise of valid
  always_ff @(posedge clk_i) begin
    if (req_sync && !ack_q && !valid_q) begin
      phase_q <= async_phase_i;
    end
  end

  assign valid_o     = valid_q;
  assign phase_o     = phase_q;
  assign async_ack_o = ack_q;

  // the receiver may only consume a phase that is actually on offer
  assert property (@(posedge clk_i) disable iff (!rst_ni) take_i |-> valid_o)
    else $error("phase taken without a valid phase on offer");

endmodule

//--- logic/clear_initiator.sv
/*
  Local initiator of a clear sequence.
  A clear_i pulse in IDLE walks through isolate, clear and post-clear,
  each phase is sent to the other domain and must both be delivered and
  locally acknowledged before the next one starts.
*/
`timescale 1ns/1ps

module clear_initiator (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          isolate_ack_i,
  input  logic                          clear_ack_i,
  output clear_phase_pkg::clear_phase_e phase_o,
  output logic                          phase_valid_o,
  input  logic                          phase_ready_i,
  output logic                          isolate_o,
  output logic                          clear_o
);
  import clear_phase_pkg::*;
  import clear_fsm_pkg::*;

  initiator_state_e state_d, state_q;

  always_comb begin
    state_d       = state_q;
    phase_o       = PHASE_IDLE;
    phase_valid_o = 1'b0;
    isolate_o     = 1'b1;
    clear_o       = 1'b0;
    case (state_q)
      // requests arriving outside IDLE are simply dropped
      IDLE: begin
        isolate_o = 1'b0;
        if (clear_i) state_d = ISOLATE;
      end
      // delivery and local acknowledge may complete in any order
      ISOLATE: begin
        phase_o       = PHASE_ISOLATE;
        phase_valid_o = 1'b1;
        if (phase_ready_i && isolate_ack_i) state_d = CLEAR;
        else if (phase_ready_i) state_d = WAIT_ISOLATE_ACK;
        else if (isolate_ack_i) state_d = WAIT_ISOLATE_PHASE_ACK;
      end
      WAIT_ISOLATE_PHASE_ACK: begin
        phase_o       = PHASE_ISOLATE;
        phase_valid_o = 1'b1;
        if (phase_ready_i) state_d = CLEAR;
      end
      WAIT_ISOLATE_ACK: begin
        phase_o = PHASE_ISOLATE;
        if (isolate_ack_i) state_d = CLEAR;
      end
      CLEAR: begin
        phase_o       = PHASE_CLEAR;
        phase_valid_o = 1'b1;
        clear_o       = 1'b1;
        if (phase_ready_i && clear_ack_i) state_d = POST_CLEAR;
        else if (phase_ready_i) state_d = WAIT_CLEAR_ACK;
        else if (clear_ack_i) state_d = WAIT_CLEAR_PHASE_ACK;
      end
      WAIT_CLEAR_PHASE_ACK: begin
        phase_o       = PHASE_CLEAR;
        phase_valid_o = 1'b1;
        clear_o       = 1'b1;
        if (phase_ready_i) state_d = POST_CLEAR;
      end
      WAIT_CLEAR_ACK: begin
        phase_o = PHASE_CLEAR;
        clear_o = 1'b1;
        if (clear_ack_i) state_d = POST_CLEAR;
      end
      // clear is down, isolate stays until the far side has seen it
      POST_CLEAR: begin
        phase_o       = PHASE_POST_CLEAR;
        phase_valid_o = 1'b1;
        if (phase_ready_i) state_d = FINISHED;
      end
      // isolate is only released here once the far side is back in idle
      FINISHED: begin
        phase_o       = PHASE_IDLE;
        phase_valid_o = 1'b1;
        if (phase_ready_i) state_d = IDLE;
      end
      default: begin
        isolate_o = 1'b0;
        state_d   = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- logic/clear_receiver.sv
/*
  Follower of a clear sequence started in the other domain.
  Each phase arriving over the crossing drives isolate and clear at once,
  but is only taken once the matching local acknowledge is high, which
  holds back the remote initiator until this side has caught up.
*/
`timescale 1ns/1ps

module clear_receiver (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  clear_phase_pkg::clear_phase_e phase_i,
  input  logic                          phase_valid_i,
  output logic                          phase_take_o,
  input  logic                          isolate_ack_i,
  input  logic                          clear_ack_i,
  output logic                          isolate_o,
  output logic                          clear_o
);
  import clear_phase_pkg::*;

  clear_phase_e phase_q;
  clear_phase_e phase_cur;
  logic         take_ok;

  // last phase taken from the crossing
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= PHASE_IDLE;
    end else if (phase_take_o) begin
      phase_q <= phase_i;
    end
  end

  // a pending phase already drives the outputs before it is taken
  assign phase_cur = phase_valid_i ? phase_i : phase_q;
  assign isolate_o = (phase_cur != PHASE_IDLE);
  assign clear_o   = (phase_cur == PHASE_CLEAR);

  // idle and post-clear need no local confirmation
  always_comb begin
    case (phase_i)
      PHASE_ISOLATE: take_ok = isolate_ack_i;
      PHASE_CLEAR:   take_ok = clear_ack_i;
      default:       take_ok = 1'b1;
    endcase
  end

  assign phase_take_o = phase_valid_i && take_ok;

endmodule

//--- logic/clear_ctrl_half.sv
/*
  One clock domain's side of the clear sequencer.
  The local initiator and the follower of the remote sequence run side by
  side, their isolate and clear are ORed so overlapping requests from both
  domains still produce one legal sequence on this side.
*/
`timescale 1ns/1ps

module clear_ctrl_half (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  clear_side_if.ctrl                    side,
  output logic                          async_req_o,
  output clear_phase_pkg::clear_phase_e async_phase_o,
  input  logic                          async_ack_i,
  input  logic                          async_req_i,
  input  clear_phase_pkg::clear_phase_e async_phase_i,
  output logic                          async_ack_o
);
  import clear_phase_pkg::*;
  import clear_fsm_pkg::*;

  clear_phase_e init_phase, rx_phase;
  logic         init_valid, init_ready, init_isolate, init_clear;
  logic         rx_valid, rx_take, rx_isolate, rx_clear;

  // ------------------------------
  // outgoing sequence
  // ------------------------------
  clear_initiator i_initiator (
    .clk_i, .rst_ni, .clear_i,
    .isolate_ack_i (side.isolate_ack), .clear_ack_i (side.clear_ack),
    .phase_o (init_phase), .phase_valid_o (init_valid), .phase_ready_i (init_ready),
    .isolate_o (init_isolate), .clear_o (init_clear)
  );

  phase_cdc_src i_src (
    .clk_i, .rst_ni,
    .phase_i (init_phase), .valid_i (init_valid), .ready_o (init_ready),
    .async_req_o, .async_phase_o, .async_ack_i
  );

  // ------------------------------
  // incoming sequence
  // ------------------------------
  phase_cdc_dst i_dst (
    .clk_i, .rst_ni, .async_req_i, .async_phase_i, .async_ack_o,
    .phase_o (rx_phase), .valid_o (rx_valid), .take_i (rx_take)
  );

  clear_receiver i_receiver (
    .clk_i, .rst_ni,
    .phase_i (rx_phase), .phase_valid_i (rx_valid), .phase_take_o (rx_take),
    .isolate_ack_i (side.isolate_ack), .clear_ack_i (side.clear_ack),
    .isolate_o (rx_isolate), .clear_o (rx_clear)
  );

  assign side.isolate = init_isolate || rx_isolate;
  assign side.clear   = init_clear || rx_clear;

  // both sources together must still keep clear nested inside isolate
  assert property (@(posedge clk_i) disable iff (!rst_ni) side.clear |-> side.isolate)
    else $error("clear is high without isolate");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(side.isolate) |-> !$past(side.clear))
    else $error("isolate fell while clear was high");
  // an idle initiator has no phase left in flight on the crossing
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (i_initiator.state_q == IDLE) |-> !async_req_o)
    else $error("crossing request high while the initiator is idle");

endmodule

//--- logic/cdc_clear_ctrl.sv
/*
  Two-sided clear sequencer for a clock-domain crossing.
  A clear pulse on either side runs isolate, clear, post-clear and idle on
  both sides in lock-step. Each side answers isolate and clear with its
  own acknowledge level, a withheld acknowledge stalls both sides.
*/
`timescale 1ns/1ps

module cdc_clear_ctrl (
  input  logic a_clk_i,
  input  logic a_rst_ni,
  input  logic a_clear_i,
  output logic a_isolate_o,
  input  logic a_isolate_ack_i,
  output logic a_clear_o,
  input  logic a_clear_ack_i,
  input  logic b_clk_i,
  input  logic b_rst_ni,
  input  logic b_clear_i,
  output logic b_isolate_o,
  input  logic b_isolate_ack_i,
  output logic b_clear_o,
  input  logic b_clear_ack_i
);
  import clear_phase_pkg::*;

  // one request, acknowledge and phase per direction
  logic         a2b_req, a2b_ack, b2a_req, b2a_ack;
  clear_phase_e a2b_phase, b2a_phase;

  clear_side_if side_a ();
  clear_side_if side_b ();

  assign side_a.isolate_ack = a_isolate_ack_i;
  assign side_a.clear_ack   = a_clear_ack_i;
  assign a_isolate_o        = side_a.isolate;
  assign a_clear_o          = side_a.clear;
  assign side_b.isolate_ack = b_isolate_ack_i;
  assign side_b.clear_ack   = b_clear_ack_i;
  assign b_isolate_o        = side_b.isolate;
  assign b_clear_o          = side_b.clear;

  clear_ctrl_half i_half_a (
    .clk_i (a_clk_i), .rst_ni (a_rst_ni), .clear_i (a_clear_i), .side (side_a),
    .async_req_o (a2b_req), .async_phase_o (a2b_phase), .async_ack_i (b2a_ack),
    .async_req_i (b2a_req), .async_phase_i (b2a_phase), .async_ack_o (a2b_ack)
  );

  clear_ctrl_half i_half_b (
    .clk_i (b_clk_i), .rst_ni (b_rst_ni), .clear_i (b_clear_i), .side (side_b),
    .async_req_o (b2a_req), .async_phase_o (b2a_phase), .async_ack_i (a2b_ack),
    .async_req_i (a2b_req), .async_phase_i (a2b_phase), .async_ack_o (b2a_ack)
  );

endmodule

//--- test/tb_cdc_clear_ctrl.sv
/*
  Testbench for the two-sided clear sequencer.
  Pulses clear on either side or on both, answers isolate and clear with
  acknowledges delayed by an LFSR draw, and checks every change of the
  isolate and clear pair on both sides against the legal sequence.
  Compile with build.f, the top module is tb_cdc_clear_ctrl.
*/
`timescale 1ns/1ps

module tb_cdc_clear_ctrl;

  logic a_clk_i, a_rst_ni, a_clear_i, a_isolate_o, a_isolate_ack_i, a_clear_o, a_clear_ack_i;
  logic b_clk_i, b_rst_ni, b_clear_i, b_isolate_o, b_isolate_ack_i, b_clear_o, b_clear_ack_i;

  logic [31:0] lfsr_q;
  int          a_iso_wait, a_clr_wait, b_iso_wait, b_clr_wait;
  logic        b_hold_iso;
  logic        strict_order;
  logic [1:0]  prev_pair [2];
  logic        cleared [2];
  int          clear_rises [2];
  int          errors, tests_run, tests_ok;
  logic        timed_out;

  cdc_clear_ctrl dut_i (.*);

  // both clocks run at 40 ns and b is shifted by 17 ns to keep the domains unrelated
  initial begin
    a_clk_i = 1'b0;
    forever #20 a_clk_i = ~a_clk_i;
  end

  initial begin
    b_clk_i = 1'b0;
    #17;
    forever #20 b_clk_i = ~b_clk_i;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  // Fibonacci form of x^32 + x^22 + x^2 + x + 1 stepped once per random bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int draw_delay();
    int d;
    d = 0;
    for (int i = 0; i < 2; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      d = (d << 1) | lfsr_q[0];
    end
    return d;
  endfunction

  // reference rule for the order idle, isolating, clearing, post-clear and idle
  // a pair of 10 is ambiguous, so the caller says whether clear was already seen
  function automatic logic [1:0] next_pair(input logic [1:0] pair, input logic was_cleared);
    case (pair)
      2'b00:   return 2'b10;
      2'b10:   return was_cleared ? 2'b00 : 2'b11;
      2'b11:   return 2'b10;
      default: return 2'bxx;
    endcase
  endfunction

  function automatic string side_name(input int s);
    return (s == 0) ? "a" : "b";
  endfunction

  function automatic logic any_active();
    return a_isolate_o | a_clear_o | b_isolate_o | b_clear_o;
  endfunction

  // one cycle of an acknowledge responder whose ack follows its level after a delay
  task automatic step_ack(input logic level, input logic hold, inout logic ack,
                          inout int wait_n);
    if (!level) begin
      ack    = 1'b0;
      wait_n = -1;
    end else if (!ack && !hold) begin
      if (wait_n < 0) wait_n = draw_delay();
      if (wait_n == 0) ack = 1'b1;
      else wait_n = wait_n - 1;
    end
  endtask

  initial forever begin
    @(posedge a_clk_i);
    #2;
    step_ack(a_isolate_o, 1'b0, a_isolate_ack_i, a_iso_wait);
    step_ack(a_clear_o, 1'b0, a_clear_ack_i, a_clr_wait);
  end

  initial forever begin
    @(posedge b_clk_i);
    #2;
    step_ack(b_isolate_o, b_hold_iso, b_isolate_ack_i, b_iso_wait);
    step_ack(b_clear_o, 1'b0, b_clear_ack_i, b_clr_wait);
  end

  // ------------------------------
  // output checker
  // ------------------------------
  // the invariants hold always and the strict order only with one initiator active
  task automatic check_pair(input int s, input logic [1:0] pair, input logic iso_ack);
    logic [1:0] want;
    string      n;
    n = side_name(s);
    if (pair !== prev_pair[s]) begin
      if (pair == 2'b01) begin
        $display("error at %0t ns: %s_clear_o high while %s_isolate_o is low", $time, n, n);
        errors++;
      end
      if (prev_pair[s] == 2'b11 && !pair[1]) begin
        $display("error at %0t ns: %s_isolate_o fell while %s_clear_o was high", $time, n, n);
        errors++;
      end
      if (pair == 2'b11) begin
        clear_rises[s]++;
        if (!iso_ack) begin
          $display("error at %0t ns: %s_clear_o rose with %s_isolate_ack_i low", $time, n, n);
          errors++;
        end
      end
      if (strict_order) begin
        want = next_pair(prev_pair[s], cleared[s]);
        if (pair !== want) begin
          $display("mismatch at %0t ns: {%s_isolate_o,%s_clear_o} expected %b, got %b",
                   $time, n, n, want, pair);
          errors++;
        end
      end
      if (pair == 2'b11) cleared[s] = 1'b1;
      if (pair == 2'b00) cleared[s] = 1'b0;
      prev_pair[s] = pair;
    end
  endtask

  // outputs only move after a rising edge so the falling edge sees them settled
  initial forever begin
    @(negedge a_clk_i);
    check_pair(0, {a_isolate_o, a_clear_o}, a_isolate_ack_i);
  end

  initial forever begin
    @(negedge b_clk_i);
    check_pair(1, {b_isolate_o, b_clear_o}, b_isolate_ack_i);
  end

  // ------------------------------
  // stimulus and waits
  // ------------------------------
  task automatic pulse_clear(input int s);
    if (s == 0) begin
      @(posedge a_clk_i);
      #2 a_clear_i = 1'b1;
      @(posedge a_clk_i);
      #2 a_clear_i = 1'b0;
    end else begin
      @(posedge b_clk_i);
      #2 b_clear_i = 1'b1;
      @(posedge b_clk_i);
      #2 b_clear_i = 1'b0;
    end
  endtask

  task automatic wait_activity(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (any_active() !== level && n < limit) begin
      @(negedge a_clk_i);
      n++;
    end
    if (any_active() !== level) begin
      $display("error at %0t ns: no %s within %0d cycles", $time, what, limit);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  // gives the crossing time to return to zero before the next test
  task automatic settle();
    repeat (20) @(negedge a_clk_i);
  endtask

  task automatic check_clear_count(input int s, input int want);
    if (clear_rises[s] != want) begin
      $display("mismatch at %0t ns: %s_clear_o pulse count expected %0d, got %0d",
               $time, side_name(s), want, clear_rises[s]);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      tests_ok++;
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  // ------------------------------
  // tests
  // ------------------------------
  task automatic run_idle_test();
    int   err_before;
    logic seen;
    err_before = errors;
    seen = 1'b0;
    repeat (50) begin
      @(negedge a_clk_i);
      if (any_active() !== 1'b0 && !seen) begin
        $display("mismatch at %0t ns: %s expected 0000, got %b", $time,
                 "{a_isolate_o,a_clear_o,b_isolate_o,b_clear_o}",
                 {a_isolate_o, a_clear_o, b_isolate_o, b_clear_o});
        errors++;
        seen = 1'b1;
      end
    end
    end_test("idle after reset", err_before);
  endtask

  task automatic run_single_test(input int s);
    int err_before;
    err_before = errors;
    clear_rises[0] = 0;
    clear_rises[1] = 0;
    pulse_clear(s);
    wait_activity(1'b1, 50, "rise of isolate");
    if (!timed_out) wait_activity(1'b0, 400, "return to idle");
    check_clear_count(0, 1);
    check_clear_count(1, 1);
    settle();
    end_test((s == 0) ? "single clear from a" : "single clear from b", err_before);
  endtask

  task automatic run_both_test();
    int err_before;
    err_before = errors;
    clear_rises[0] = 0;
    clear_rises[1] = 0;
    // two initiators interleave, so only the invariants are checked
    strict_order = 1'b0;
    fork
      pulse_clear(0);
      pulse_clear(1);
    join
    wait_activity(1'b1, 50, "rise of isolate");
    if (!timed_out) wait_activity(1'b0, 800, "return to idle");
    for (int s = 0; s < 2; s++) begin
      if (clear_rises[s] < 1) begin
        $display("error at %0t ns: %s_clear_o never pulsed", $time, side_name(s));
        errors++;
      end
    end
    settle();
    strict_order = 1'b1;
    end_test("simultaneous clears", err_before);
  endtask

  task automatic run_backpressure_test();
    int err_before;
    err_before = errors;
    clear_rises[0] = 0;
    clear_rises[1] = 0;
    b_hold_iso = 1'b1;
    pulse_clear(0);
    repeat (60) @(negedge a_clk_i);
    check_clear_count(0, 0);
    check_clear_count(1, 0);
    if (b_isolate_o !== 1'b1) begin
      $display("mismatch at %0t ns: b_isolate_o expected 1, got %b", $time, b_isolate_o);
      errors++;
    end
    b_hold_iso = 1'b0;
    wait_activity(1'b0, 400, "return to idle after release");
    check_clear_count(0, 1);
    check_clear_count(1, 1);
    settle();
    end_test("withheld isolate acknowledge on b", err_before);
  endtask

  initial begin
    a_rst_ni        = 1'b0;
    b_rst_ni        = 1'b0;
    a_clear_i       = 1'b0;
    b_clear_i       = 1'b0;
    a_isolate_ack_i = 1'b0;
    a_clear_ack_i   = 1'b0;
    b_isolate_ack_i = 1'b0;
    b_clear_ack_i   = 1'b0;
    lfsr_q          = 32'hff1d;
    a_iso_wait      = -1;
    a_clr_wait      = -1;
    b_iso_wait      = -1;
    b_clr_wait      = -1;
    b_hold_iso      = 1'b0;
    strict_order    = 1'b1;
    prev_pair[0]    = 2'b00;
    prev_pair[1]    = 2'b00;
    cleared[0]      = 1'b0;
    cleared[1]      = 1'b0;
    errors          = 0;
    tests_run       = 0;
    tests_ok        = 0;
    timed_out       = 1'b0;
    fork
      begin
        repeat (2) @(posedge a_clk_i);
        #2 a_rst_ni = 1'b1;
      end
      begin
        repeat (2) @(posedge b_clk_i);
        #2 b_rst_ni = 1'b1;
      end
    join
    run_idle_test();
    if (!timed_out) run_single_test(0);
    if (!timed_out) run_single_test(1);
    if (!timed_out) run_both_test();
    if (!timed_out) run_backpressure_test();
    $display("summary: %0d run, %0d ok, %0d not ok, %0d check errors",
             tests_run, tests_ok, tests_run - tests_ok, errors);
    if (errors == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+logic
logic/clear_phase_pkg.sv
logic/clear_fsm_pkg.sv
logic/clear_side_if.sv
logic/phase_cdc_src.sv
logic/phase_cdc_dst.sv
logic/clear_initiator.sv
logic/clear_receiver.sv
logic/clear_ctrl_half.sv
logic/cdc_clear_ctrl.sv
test/tb_cdc_clear_ctrl.sv

//--- Bender.yml
package:
  name: cdc_clear_ctrl

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/clear_phase_pkg.sv
      - logic/clear_fsm_pkg.sv
      - logic/clear_side_if.sv
      - logic/phase_cdc_src.sv
      - logic/phase_cdc_dst.sv
      - logic/clear_initiator.sv
      - logic/clear_receiver.sv
      - logic/clear_ctrl_half.sv
      - logic/cdc_clear_ctrl.sv
  - target: test
    files:
      - test/tb_cdc_clear_ctrl.sv
